/* sources.f */
+incdir+testbench
design/issue_cmd_pkg.sv
design/issue_cfg_pkg.sv
design/pipe_slice.sv
design/capacity_gate.sv
design/burst_expander.sv
design/word_fifo.sv
design/burst_issue_top.sv
testbench/tb_burst_issue.sv

/* testbench/tb_checks.svh */
/*
 * Error counters and compare tasks for the burst issue testbench.
 * Included inside the testbench module after CAPACITY_WIDTH is declared.
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

task automatic check_user(input cmd_user_t got, input cmd_user_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: word_user = 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

task automatic check_beat(input beat_t got, input beat_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: word_beat = 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

task automatic check_capacity(input logic [CAPACITY_WIDTH-1:0] got,
                              input logic [CAPACITY_WIDTH-1:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: current_capacity = 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

// timeouts and other slips
task automatic report_problem(input string what);
    other_errors++;
    $display("At %0t: %s", $time, what);
endtask

`endif

/* testbench/tb_burst_issue.sv */
/*
 * Testbench for the burst issue throttle.
 * Random commands and word_ready back-pressure from a fixed seed; every
 * word is checked against a queue model filled by accepted commands.
 */

`timescale 1ns/1ps

module tb_burst_issue
    import issue_cmd_pkg::*;
();

    localparam int CAPACITY_WIDTH = 16;
    localparam int LIMIT          = 5000;
    localparam logic [CAPACITY_WIDTH-1:0] CAP_INIT = 64;

    logic                      clk;
    logic                      reset;
    logic [CAPACITY_WIDTH-1:0] initial_capacity;
    logic [CAPACITY_WIDTH-1:0] current_capacity;
    cmd_user_t                 cmd_user;
    cmd_size_t                 cmd_size;
    logic                      cmd_valid;
    logic                      cmd_ready;
    cmd_user_t                 word_user;
    beat_t                     word_beat;
    logic                      word_valid;
    logic                      word_ready;
    logic                      hold_low;
    integer                    seed = 32'he55d44c2;
    integer                    ready_seed = 32'he55d44c2;
    cmd_user_t                 exp_user[$];
    beat_t                     exp_beat[$];

    `include "tb_checks.svh"

    burst_issue_top #(.CAPACITY_WIDTH(CAPACITY_WIDTH), .FIFO_DEPTH(64)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // word_ready random, or held low for back-pressure
    always @(posedge clk) begin
        word_ready <= !hold_low && ($random(ready_seed) % 4 != 0);
    end

    // ------------------------------
    // model queue and scoreboard
    // ------------------------------
    always @(posedge clk) begin
        if (!reset && word_valid && word_ready) begin
            if (exp_user.size() == 0) begin
                report_problem("a word came out that no command asked for");
            end else begin
                check_user(word_user, exp_user.pop_front());
                check_beat(word_beat, exp_beat.pop_front());
            end
        end
        if (!reset && cmd_valid && cmd_ready) begin
            for (int b = 0; b <= int'(cmd_size); b++) begin
                exp_user.push_back(cmd_user);
                exp_beat.push_back(beat_t'(b));
            end
        end
    end

    // mostly short bursts, some near the full 64 words
    function automatic cmd_size_t random_size();
        int pick;
        pick = $random(seed) & 3;
        if (pick == 3) return cmd_size_t'(56 + ($random(seed) & 7));
        return cmd_size_t'($random(seed) & (pick == 2 ? 31 : 7));
    endfunction

    task automatic finish_cmd();
        int   waited;
        logic accepted;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            accepted = cmd_ready;
        end while (!accepted && waited < LIMIT);
        if (!accepted) report_problem("timeout waiting for cmd_ready");
        cmd_valid <= 1'b0;
    endtask

    task automatic send_cmd(input cmd_user_t user, input cmd_size_t size);
        cmd_user  <= user;
        cmd_size  <= size;
        cmd_valid <= 1'b1;
        finish_cmd();
    endtask

    // drain all words, idle, then the full capacity must be back
    task automatic quiesce();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((exp_user.size() != 0 || word_valid) && waited < LIMIT);
        if (exp_user.size() != 0 || word_valid) report_problem("timeout waiting for drain");
        repeat (5) @(posedge clk);
        check_capacity(current_capacity, CAP_INIT);
    endtask

    task automatic fill_stalled();
        int waited;
        int low_run;
        waited  = 0;
        low_run = 0;
        hold_low  <= 1'b1;
        cmd_user  <= cmd_user_t'($random(seed));
        cmd_size  <= random_size();
        cmd_valid <= 1'b1;
        // a long burst can stall cmd_ready for up to 64 cycles
        while (low_run < 100 && waited < LIMIT) begin
            @(posedge clk);
            waited++;
            low_run = cmd_ready ? 0 : low_run + 1;
            if (cmd_ready) begin
                cmd_user <= cmd_user_t'($random(seed));
                cmd_size <= random_size();
            end
        end
        if (low_run < 100) report_problem("cmd_ready never stayed low under back-pressure");
        hold_low <= 1'b0;
        finish_cmd();
    endtask

    initial begin
        reset            = 1'b1;
        initial_capacity = CAP_INIT;
        cmd_user         = '0;
        cmd_size         = '0;
        cmd_valid        = 1'b0;
        word_ready       = 1'b0;
        hold_low         = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        check_capacity(current_capacity, CAP_INIT);
        if (word_valid) report_problem("word_valid is high right after reset");

        for (int round = 0; round < 4; round++) begin
            for (int n = 0; n < 40; n++) begin
                send_cmd(cmd_user_t'($random(seed)), random_size());
                repeat ($random(seed) & 3) @(posedge clk);
            end
            quiesce();
        end

        fill_stalled();
        quiesce();

        // two short bursts debited, the full-length one held at the gate
        hold_low <= 1'b1;
        send_cmd(4'h1, 8'd3);
        send_cmd(4'h2, 8'd5);
        send_cmd(4'h3, 8'd63);
        repeat (40) @(posedge clk);
        check_capacity(current_capacity, CAP_INIT - 4 - 6);
        hold_low <= 1'b0;
        quiesce();

        if (exp_user.size() != 0) report_problem("words still expected at end of run");
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* design/burst_issue_top.sv */
/*
 * Burst issue throttle top level.
 * Commands pass the capacity gate, are expanded into tagged words and
 * land in the word FIFO, whose pops return capacity to the gate.
 */

`timescale 1ns/1ps

module burst_issue_top import issue_cmd_pkg::*; #(
    parameter int CAPACITY_WIDTH = 16,
    parameter int FIFO_DEPTH     = 64,
    parameter bit S_REGS         = 1'b1,
    parameter bit M_REGS         = 1'b1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [CAPACITY_WIDTH-1:0] initial_capacity,
    output logic [CAPACITY_WIDTH-1:0] current_capacity,
    input  cmd_user_t                 cmd_user,
    input  cmd_size_t                 cmd_size,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    output cmd_user_t                 word_user,
    output beat_t                     word_beat,
    output logic                      word_valid,
    input  logic                      word_ready
);

    cmd_user_t issue_user;
    cmd_size_t issue_size;
    logic      issue_valid;
    logic      issue_ready;
    cmd_user_t push_user;
    beat_t     push_beat;
    logic      push_valid;
    logic      push_ready;
    logic      charge_valid;

    capacity_gate #(
        .CAPACITY_WIDTH (CAPACITY_WIDTH),
        .S_REGS         (S_REGS),
        .M_REGS         (M_REGS)
    ) i_gate (
        .clk              (clk),
        .reset            (reset),
        .initial_capacity (initial_capacity),
        .current_capacity (current_capacity),
        .charge_valid     (charge_valid),
        .s_user           (cmd_user),
        .s_size           (cmd_size),
        .s_valid          (cmd_valid),
        .s_ready          (cmd_ready),
        .m_user           (issue_user),
        .m_size           (issue_size),
        .m_valid          (issue_valid),
        .m_ready          (issue_ready)
    );

    burst_expander i_expander (
        .clk         (clk),
        .reset       (reset),
        .issue_user  (issue_user),
        .issue_size  (issue_size),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .push_user   (push_user),
        .push_beat   (push_beat),
        .push_valid  (push_valid),
        .push_ready  (push_ready)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk          (clk),
        .reset        (reset),
        .push_user    (push_user),
        .push_beat    (push_beat),
        .push_valid   (push_valid),
        .push_ready   (push_ready),
        .word_user    (word_user),
        .word_beat    (word_beat),
        .word_valid   (word_valid),
        .word_ready   (word_ready),
        .charge_valid (charge_valid)
    );

endmodule

/* design/word_fifo.sv */
/*
 * Word FIFO between the burst expander and the output port.
 * Registered output with a bypass so a push shows up on the next cycle.
 * Every pop raises charge_valid for that cycle to return capacity.
 */

`timescale 1ns/1ps

module word_fifo import issue_cmd_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  cmd_user_t push_user,
    input  beat_t     push_beat,
    input  logic      push_valid,
    output logic      push_ready,
    output cmd_user_t word_user,
    output beat_t     word_beat,
    output logic      word_valid,
    input  logic      word_ready,
    output logic      charge_valid
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    cmd_user_t       mem_user [FIFO_DEPTH];
    beat_t           mem_beat [FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            mem_empty;
    logic            full;
    logic            push;
    logic            pop;
    logic            load_out;
    logic            bypass;

    // extra pointer bit tells full from empty
    assign mem_empty = wr_ptr == rd_ptr;
    assign full      = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign push_ready = !full;
    assign push       = push_valid && push_ready;
    assign pop        = word_valid && word_ready;
    assign load_out   = !word_valid || pop;
    assign bypass     = push && mem_empty && load_out;

    // ------------------------------
    // pointers and output valid
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            word_valid <= 1'b0;
        end else begin
            if (push && !bypass) wr_ptr <= wr_ptr + 1'b1;
            if (load_out && !mem_empty) rd_ptr <= rd_ptr + 1'b1;
            if (load_out) word_valid <= !mem_empty || push;
        end
    end

    // storage and output register
    always_ff @(posedge clk) begin
        if (push && !bypass) begin
            mem_user[wr_ptr[ADDR_W-1:0]] <= push_user;
            mem_beat[wr_ptr[ADDR_W-1:0]] <= push_beat;
        end
        if (load_out) begin
            word_user <= mem_empty ? push_user : mem_user[rd_ptr[ADDR_W-1:0]];
            word_beat <= mem_empty ? push_beat : mem_beat[rd_ptr[ADDR_W-1:0]];
        end
    end

    assign charge_valid = pop;

    // the gate debits ahead of time, so a full FIFO is never pushed
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        push_valid |-> !full);

endmodule

/* design/burst_expander.sv */
/*
 * Burst expander.
 * Accepts one command at a time and pushes (size + 1) words carrying
 * its tag and a beat index counting up from zero.
 */

`timescale 1ns/1ps

module burst_expander import issue_cmd_pkg::*, issue_cfg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  cmd_user_t issue_user,
    input  cmd_size_t issue_size,
    input  logic      issue_valid,
    output logic      issue_ready,
    output cmd_user_t push_user,
    output beat_t     push_beat,
    output logic      push_valid,
    input  logic      push_ready
);

    logic      busy;
    beat_t     beat;
    cmd_user_t cur_user;
    cmd_size_t cur_size;
    logic      accept;
    logic      push_fire;

    assign issue_ready = !busy;
    assign accept      = issue_valid && issue_ready;
    assign push_fire   = push_valid && push_ready;

    // ------------------------------
    // beat counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            beat <= '0;
        end else if (push_fire) begin
            if (is_last_beat(beat, cur_size)) begin
                busy <= 1'b0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    // command held for the whole burst
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_user <= issue_user;
            cur_size <= issue_size;
        end
    end

    assign push_valid = busy;
    assign push_user  = cur_user;
    assign push_beat  = beat;

endmodule

/* design/capacity_gate.sv */
/*
 * Capacity gate for burst commands.
 * Holds a command until current_capacity covers its burst length,
 * debits the length on issue and credits CHARGE_UNIT per charge strobe.
 * Optional slices on both sides are chosen by S_REGS and M_REGS.
 */

`timescale 1ns/1ps

module capacity_gate import issue_cmd_pkg::*, issue_cfg_pkg::*; #(
    parameter int CAPACITY_WIDTH = 16,
    parameter bit S_REGS         = 1'b1,
    parameter bit M_REGS         = 1'b1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [CAPACITY_WIDTH-1:0] initial_capacity,
    output logic [CAPACITY_WIDTH-1:0] current_capacity,
    input  logic                      charge_valid,
    input  cmd_user_t                 s_user,
    input  cmd_size_t                 s_size,
    input  logic                      s_valid,
    output logic                      s_ready,
    output cmd_user_t                 m_user,
    output cmd_size_t                 m_size,
    output logic                      m_valid,
    input  logic                      m_ready
);

    // ------------------------------
    // input slice and rx stage
    // ------------------------------
    cmd_user_t                 in_user;
    cmd_size_t                 in_size;
    logic                      in_valid;
    logic                      in_ready;
    cmd_user_t                 rx_user;
    cmd_size_t                 rx_size;
    logic                      rx_valid;
    logic                      rx_ready;
    logic [CAPACITY_WIDTH-1:0] rx_issue;

    pipe_slice #(.REGS(S_REGS)) i_in_slice (
        .clk     (clk),
        .reset   (reset),
        .s_user  (s_user),
        .s_size  (s_size),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_user  (in_user),
        .m_size  (in_size),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    if (S_REGS) begin : g_rx_reg
        always_ff @(posedge clk) begin
            if (reset) begin
                rx_valid <= 1'b0;
            end else if (in_ready) begin
                rx_valid <= in_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (in_ready) begin
                rx_user <= in_user;
                rx_size <= in_size;
            end
        end

        assign in_ready = !rx_valid || rx_ready;
    end else begin : g_rx_bypass
        assign rx_user  = in_user;
        assign rx_size  = in_size;
        assign rx_valid = in_valid;
        assign in_ready = rx_ready;
    end

    // zero when idle so the compare never blocks
    assign rx_issue = rx_valid ? CAPACITY_WIDTH'(burst_length(rx_size)) : '0;

    // ------------------------------
    // capacity counter
    // ------------------------------
    logic [CAPACITY_WIDTH-1:0] charge_q;
    logic [CAPACITY_WIDTH-1:0] capacity_q;
    logic [CAPACITY_WIDTH-1:0] capacity_sub_q;
    logic                      select_sub;
    logic                      cap_loaded;
    logic                      issue_enable;
    logic                      tx_ready;
    logic                      issue_fire;

    assign issue_enable = current_capacity >= rx_issue;
    assign rx_ready     = tx_ready && issue_enable;
    assign issue_fire   = rx_valid && rx_ready;

    // charge register doubles as the initial load after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            charge_q   <= initial_capacity;
            capacity_q <= '0;
            select_sub <= 1'b0;
            cap_loaded <= 1'b0;
        end else begin
            charge_q   <= charge_valid ? CAPACITY_WIDTH'(CHARGE_UNIT) : '0;
            capacity_q <= current_capacity + charge_q;
            select_sub <= issue_fire;
            cap_loaded <= 1'b1;
        end
    end

    // debited copy, picked only after an issue
    always_ff @(posedge clk) begin
        capacity_sub_q <= current_capacity + charge_q - rx_issue;
    end

    assign current_capacity = select_sub ? capacity_sub_q : capacity_q;

    // ------------------------------
    // output slice
    // ------------------------------
    pipe_slice #(.REGS(M_REGS)) i_out_slice (
        .clk     (clk),
        .reset   (reset),
        .s_user  (rx_user),
        .s_size  (rx_size),
        .s_valid (rx_valid && issue_enable),
        .s_ready (tx_ready),
        .m_user  (m_user),
        .m_size  (m_size),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    // every unit handed out comes back through a pop downstream
    a_capacity_bounded: assert property (@(posedge clk) disable iff (reset)
        cap_loaded |-> current_capacity <= initial_capacity);

endmodule

/* design/pipe_slice.sv */
/*
 * Valid/ready register slice for a command (tag and size).
 * REGS = 1 gives a full-throughput slice with a skid register so that
 * s_ready is registered; REGS = 0 passes everything straight through.
 */

`timescale 1ns/1ps

module pipe_slice import issue_cmd_pkg::*; #(
    parameter bit REGS = 1'b1
) (
    input  logic      clk,
    input  logic      reset,
    input  cmd_user_t s_user,
    input  cmd_size_t s_size,
    input  logic      s_valid,
    output logic      s_ready,
    output cmd_user_t m_user,
    output cmd_size_t m_size,
    output logic      m_valid,
    input  logic      m_ready
);

    if (REGS) begin : g_regs
        logic      main_valid;
        cmd_user_t main_user;
        cmd_size_t main_size;
        logic      skid_valid;
        cmd_user_t skid_user;
        cmd_size_t skid_size;
        logic      load_main;

        // skid is only ever filled while main is stalled
        assign s_ready   = !skid_valid;
        assign load_main = !main_valid || m_ready;

        always_ff @(posedge clk) begin
            if (reset) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
            end else begin
                if (load_main) begin
                    main_valid <= skid_valid || s_valid;
                    skid_valid <= 1'b0;
                end else if (s_valid && s_ready) begin
                    skid_valid <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (load_main) begin
                main_user <= skid_valid ? skid_user : s_user;
                main_size <= skid_valid ? skid_size : s_size;
            end
            if (s_ready) begin
                skid_user <= s_user;
                skid_size <= s_size;
            end
        end

        assign m_user  = main_user;
        assign m_size  = main_size;
        assign m_valid = main_valid;
    end else begin : g_bypass
        assign s_ready = m_ready;
        assign m_user  = s_user;
        assign m_size  = s_size;
        assign m_valid = s_valid;
    end

    // stalled input holds its payload until the slice takes it
    a_stable_when_stalled: assert property (@(posedge clk) disable iff (reset)
        s_valid && !s_ready |=> $stable(s_user) && $stable(s_size));

endmodule

/* design/issue_cfg_pkg.sv */
/*
 * Length encoding constants and helper functions for the issue path.
 * Used by the capacity gate, the burst expander and the testbench
 * to agree on how a size field maps to a burst length.
 */

package issue_cfg_pkg;

    import issue_cmd_pkg::*;

    // ------------------------------
    // encoding constants
    // ------------------------------

    // size field is length minus one
    localparam bit CMD_SIZE_OFFSET = 1'b1;

    // capacity returned by one charge strobe
    localparam int CHARGE_UNIT = 1;

    // ------------------------------
    // helpers
    // ------------------------------

    // words in a burst, one bit wider than the size field
    function automatic logic [8:0] burst_length(input cmd_size_t size);
        return {1'b0, size} + 9'(CMD_SIZE_OFFSET);
    endfunction

    // true on the final word of a burst
    function automatic logic is_last_beat(input beat_t beat, input cmd_size_t size);
        return beat == size;
    endfunction

endpackage

/* design/issue_cmd_pkg.sv */
/*
 * Command and word field types for the burst issue throttle.
 * Import into any module or testbench that carries a command tag,
 * a burst size or a beat index.
 */

package issue_cmd_pkg;

    // ------------------------------
    // command fields
    // ------------------------------

    // user tag, travels with every word of the burst
    typedef logic [3:0] cmd_user_t;

    // burst length minus one
    typedef logic [7:0] cmd_size_t;

    // ------------------------------
    // word fields
    // ------------------------------

    // index of a word inside its burst, 0 up to size
    typedef logic [7:0] beat_t;

endpackage
